//--- sim.f
verilog/geom_pkg.sv
verilog/proj_pkg.sv
verilog/dot3_fixed.sv
verilog/fixed_div.sv
verilog/vertex_projector.sv
verilog/vertex_dispatch.sv
verilog/result_collect.sv
verilog/projection_top.sv
tests/tb_projection.sv

//--- tests/tb_projection.sv
`timescale 1ns/1ps

module tb_projection import geom_pkg::*, proj_pkg::*; ();

  localparam int num_lanes    = 3;
  localparam int half_w       = 160;
  localparam int half_h       = 120;
  localparam int focal_shift  = 8;
  localparam int accept_limit = 200;   // cycles
  localparam int drain_limit  = 2000;  // cycles
  localparam int num_tags     = 1 << tag_width;
  localparam int num_random   = 12;
  localparam logic signed [vec_width-1:0] one = vec_width'(1 << frac_bits);

  logic clk_in = 1'b0;
  logic rst_in;
  logic vtx_valid;
  logic signed [pos_width-1:0] vtx_x, vtx_y, vtx_z;
  logic signed [cam_width-1:0] cam_x, cam_y, cam_z;
  logic signed [vec_width-1:0] u_x, u_y, u_z, v_x, v_y, v_z, n_x, n_y, n_z;
  logic res_ready;
  logic vtx_accept;
  logic res_valid;
  logic [tag_width-1:0] res_tag;
  logic res_culled;
  logic signed [screen_width-1:0] res_x, res_y;
  logic signed [dot_width-1:0] res_depth;

  // reference model results, indexed by tag
  bit pending [num_tags];
  bit exp_culled [num_tags];
  logic signed [screen_width-1:0] exp_x [num_tags];
  logic signed [screen_width-1:0] exp_y [num_tags];
  logic signed [dot_width-1:0] exp_depth [num_tags];

  int sent = 0;
  int received = 0;
  logic [tag_width-1:0] next_tag = '0;  // mirrors the dispatcher counter
  string test_name = "reset";
  integer seed;
  bit stall_on = 1'b0;
  bit saw_accept_low = 1'b0;
  int rnd_x [num_random];
  int rnd_y [num_random];
  int rnd_z [num_random];

  projection_top #(.num_lanes(num_lanes), .half_w(half_w), .half_h(half_h),
                   .focal_shift(focal_shift)) DUT (
    .clk_in(clk_in), .rst_in(rst_in), .vtx_valid(vtx_valid),
    .vtx_x(vtx_x), .vtx_y(vtx_y), .vtx_z(vtx_z),
    .cam_x(cam_x), .cam_y(cam_y), .cam_z(cam_z),
    .u_x(u_x), .u_y(u_y), .u_z(u_z), .v_x(v_x), .v_y(v_y), .v_z(v_z),
    .n_x(n_x), .n_y(n_y), .n_z(n_z), .res_ready(res_ready),
    .vtx_accept(vtx_accept), .res_valid(res_valid), .res_tag(res_tag),
    .res_culled(res_culled), .res_x(res_x), .res_y(res_y), .res_depth(res_depth)
  );

  always #50 clk_in = ~clk_in;

  task automatic abort_run(input string what);
    $display("ERROR in %s: %s", test_name, what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string field, input int expected, input int actual);
    $display("FAIL %s %s expected %0d actual %0d", test_name, field, expected, actual);
    abort_run("wrong result value");
  endtask

  // camera at the origin with identity basis, so the dots are the raw coordinates
  function automatic void predict(input logic [tag_width-1:0] tag, input int x, input int y,
                                  input int z);
    int qx;
    int qy;
    qx = 0;
    qy = 0;
    if (z > 0) begin
      qx = (x * (1 << focal_shift)) / z;  // int division truncates toward zero
      qy = (y * (1 << focal_shift)) / z;
    end
    exp_culled[tag] = (z <= 0) ||
                      !(qx > -half_w && qx < half_w && qy > -half_h && qy < half_h);
    exp_x[tag]      = exp_culled[tag] ? '0 : screen_width'(qx + half_w);
    exp_y[tag]      = exp_culled[tag] ? '0 : screen_width'(half_h - qy);
    exp_depth[tag]  = dot_width'(z);
    pending[tag]    = 1'b1;
  endfunction

  // at most one strobe every other cycle, so vtx_accept already counts the last one
  task automatic send_vertex(input int x, input int y, input int z);
    int waited;
    waited = 0;
    @(posedge clk_in);
    while (!vtx_accept) begin
      if (waited == accept_limit) abort_run("vtx_accept stayed low too long");
      waited++;
      @(posedge clk_in);
    end
    if (pending[next_tag]) abort_run("tag reused while still in flight");
    predict(next_tag, x, y, z);
    vtx_valid <= 1'b1;
    vtx_x     <= pos_width'(x);
    vtx_y     <= pos_width'(y);
    vtx_z     <= pos_width'(z);
    next_tag  = next_tag + 1'b1;
    sent++;
    @(posedge clk_in);
    vtx_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (received != sent) begin
      if (waited == drain_limit) abort_run("results missing after timeout");
      waited++;
      @(posedge clk_in);
    end
  endtask

  // consumer side
  always @(posedge clk_in) begin
    if (stall_on) res_ready <= (($random(seed) & 3) != 0);  // about one stall in four
    else res_ready <= 1'b1;
  end

  always @(posedge clk_in) begin
    if (!rst_in && res_valid && res_ready) begin
      pending[res_tag] <= 1'b0;
      received         <= received + 1;
    end
    if (!rst_in && !vtx_accept) saw_accept_low <= 1'b1;
  end

  reset_state: assert property (@(posedge clk_in) $fell(rst_in) |-> !res_valid && vtx_accept)
    else abort_run("outputs not in their reset state after reset");

  tag_outstanding: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid && res_ready |-> pending[res_tag])
    else abort_run("result with a tag that is not outstanding");

  culled_ok: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid && res_ready |-> res_culled == exp_culled[res_tag])
    else report_mismatch("res_culled", exp_culled[$sampled(res_tag)], $sampled(res_culled));

  x_ok: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid && res_ready |-> res_x == exp_x[res_tag])
    else report_mismatch("res_x", exp_x[$sampled(res_tag)], $sampled(res_x));

  y_ok: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid && res_ready |-> res_y == exp_y[res_tag])
    else report_mismatch("res_y", exp_y[$sampled(res_tag)], $sampled(res_y));

  depth_ok: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid && res_ready |-> res_depth == exp_depth[res_tag])
    else report_mismatch("res_depth", exp_depth[$sampled(res_tag)], $sampled(res_depth));

  hold_while_stalled: assert property (@(posedge clk_in) disable iff (rst_in)
    res_valid && !res_ready |=> res_valid && $stable(res_tag) && $stable(res_culled) &&
                               $stable(res_x) && $stable(res_y) && $stable(res_depth))
    else abort_run("result changed while res_ready was low");

  initial begin
    seed      = 32'h693c_054f;
    rst_in    = 1'b1;
    vtx_valid = 1'b0;
    vtx_x     = '0;
    vtx_y     = '0;
    vtx_z     = '0;
    cam_x     = '0;
    cam_y     = '0;
    cam_z     = '0;
    u_x       = one;
    u_y       = '0;
    u_z       = '0;
    v_x       = '0;
    v_y       = one;
    v_z       = '0;
    n_x       = '0;
    n_y       = '0;
    n_z       = one;
    res_ready = 1'b1;
    repeat (3) @(posedge clk_in);
    rst_in <= 1'b0;

    test_name = "axis vertex";
    send_vertex(0, 0, 64);
    wait_drained();

    test_name = "depth cull";
    send_vertex(10, 5, 0);
    send_vertex(3, -4, -20);
    wait_drained();

    test_name = "viewport cull";
    send_vertex(1000, 0, 64);
    send_vertex(40, 0, 64);    // lands exactly on the right edge
    send_vertex(0, -30, 64);   // and on the bottom edge
    send_vertex(39, -29, 64);  // just inside
    wait_drained();

    test_name = "burst";
    saw_accept_low = 1'b0;  // all lanes idle here, only the burst can set it
    for (int i = 0; i < 6; i++) begin
      send_vertex(i * 9 - 20, 12 - i * 7, 80 + i * 16);
    end
    wait_drained();
    assert (saw_accept_low) else abort_run("vtx_accept never dropped during the burst");

    test_name = "random stall";
    for (int i = 0; i < num_random; i++) begin
      rnd_x[i] = $random(seed) % 200;
      rnd_y[i] = $random(seed) % 150;
      rnd_z[i] = $random(seed) % 400;
    end
    stall_on <= 1'b1;
    for (int i = 0; i < num_random; i++) begin
      send_vertex(rnd_x[i], rnd_y[i], rnd_z[i]);
    end
    wait_drained();
    stall_on <= 1'b0;

    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog/dot3_fixed.sv
`timescale 1ns/1ps

module dot3_fixed import geom_pkg::*; (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic signed [rel_width-1:0] a_x,
  input  logic signed [rel_width-1:0] a_y,
  input  logic signed [rel_width-1:0] a_z,
  input  logic signed [vec_width-1:0] b_x,
  input  logic signed [vec_width-1:0] b_y,
  input  logic signed [vec_width-1:0] b_z,
  output logic signed [dot_width-1:0] dot
);

  localparam int prod_width = rel_width + vec_width;

  logic signed [prod_width-1:0] prod_x;
  logic signed [prod_width-1:0] prod_y;
  logic signed [prod_width-1:0] prod_z;
  logic signed [prod_width+1:0] sum;

  // three terms need two more bits
  assign sum = prod_x + prod_y + prod_z;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      prod_x <= '0;
      prod_y <= '0;
      prod_z <= '0;
      dot    <= '0;
    end else begin
      prod_x <= a_x * b_x;  // stage 1
      prod_y <= a_y * b_y;
      prod_z <= a_z * b_z;
      // stage 2, back to the input scale
      dot    <= dot_width'(sum >>> frac_bits);
    end
  end

endmodule

//--- verilog/fixed_div.sv
`timescale 1ns/1ps

module fixed_div import geom_pkg::*, proj_pkg::*; (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         start,
  input  logic signed [quot_width-1:0] dividend,
  input  logic signed [quot_width-1:0] divisor,
  output logic                         busy,
  output logic                         done,
  output logic                         zerodiv,
  output logic signed [quot_width-1:0] quotient
);

  localparam int cnt_width = $clog2(quot_width);

  div_state_t           state;
  logic [cnt_width-1:0] step;
  logic [quot_width-1:0] rem;
  logic [quot_width-1:0] shreg;  // dividend bits out, quotient bits in
  logic [quot_width-1:0] den;
  logic                  neg;
  logic [quot_width-1:0] dividend_mag;
  logic [quot_width-1:0] divisor_mag;
  logic [quot_width:0]   trial;
  logic [quot_width:0]   diff;
  logic                  fits;

  assign dividend_mag = dividend[quot_width-1] ? $unsigned(-dividend) : $unsigned(dividend);
  assign divisor_mag  = divisor[quot_width-1] ? $unsigned(-divisor) : $unsigned(divisor);

  // one restoring step
  assign trial = {rem, shreg[quot_width-1]};
  assign diff  = trial - {1'b0, den};
  assign fits  = trial >= {1'b0, den};

  assign busy = (state != DIV_IDLE);
  assign done = (state == DIV_DONE);  // single cycle, then back to idle

  // sign goes on at the end, truncation toward zero
  assign quotient = zerodiv ? '0 : (neg ? -$signed(shreg) : $signed(shreg));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= DIV_IDLE;
      step    <= '0;
      zerodiv <= 1'b0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (start) begin
            state   <= DIV_RUN;
            step    <= '0;
            zerodiv <= (divisor == '0);
          end
        end
        DIV_RUN: begin
          step <= step + 1'b1;
          if (step == cnt_width'(quot_width - 1)) state <= DIV_DONE;
        end
        DIV_DONE: state <= DIV_IDLE;
        default:  state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == DIV_IDLE && start) begin
      rem   <= '0;
      shreg <= dividend_mag;
      den   <= divisor_mag;
      neg   <= dividend[quot_width-1] ^ divisor[quot_width-1];
    end else if (state == DIV_RUN) begin
      rem   <= fits ? diff[quot_width-1:0] : trial[quot_width-1:0];
      shreg <= {shreg[quot_width-2:0], fits};
    end
  end

  // the lane must not restart a divider that is still working
  start_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    start |-> !busy)
    else $error("fixed_div started while busy");

endmodule

//--- verilog/geom_pkg.sv
package geom_pkg;

  // fixed point format shared by the whole projection path
  localparam int frac_bits = 14;

  // raw vertex coordinate from the geometry stage
  localparam int pos_width = 16;

  // camera position, a little wider so it can sit outside the model
  localparam int cam_width = 18;

  // unit basis component, 1.0 is 1 << frac_bits
  localparam int vec_width = 16;

  // vertex minus camera needs one extra bit
  localparam int rel_width = cam_width + 1;

  // dot product after dropping frac_bits
  // two guard bits for the sum of three terms
  localparam int dot_width = rel_width + vec_width - frac_bits + 2;

  // divider operand and quotient width
  localparam int quot_width = 2 * frac_bits + 1;

  // viewport coordinate, signed
  localparam int screen_width = 12;

endpackage

//--- verilog/proj_pkg.sv
package proj_pkg;

  // per lane control
  typedef enum logic [1:0] {
    IDLE,    // waiting for a start from the dispatcher
    DOT,     // dot products in flight
    DIVIDE,  // both dividers running
    HOLD     // result ready, waiting for the collector
  } lane_state_t;

  // sequential divider control
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_t;

  localparam int tag_width = 4;  // wraps, consumer matches results by tag

endpackage

//--- verilog/projection_top.sv
`timescale 1ns/1ps

module projection_top import geom_pkg::*, proj_pkg::*; #(
  parameter int num_lanes   = 3,
  parameter int half_w      = 160,
  parameter int half_h      = 120,
  parameter int focal_shift = 8
) (
  input  logic                           clk_in,
  input  logic                           rst_in,
  input  logic                           vtx_valid,
  input  logic signed [pos_width-1:0]    vtx_x,
  input  logic signed [pos_width-1:0]    vtx_y,
  input  logic signed [pos_width-1:0]    vtx_z,
  input  logic signed [cam_width-1:0]    cam_x,
  input  logic signed [cam_width-1:0]    cam_y,
  input  logic signed [cam_width-1:0]    cam_z,
  input  logic signed [vec_width-1:0]    u_x,
  input  logic signed [vec_width-1:0]    u_y,
  input  logic signed [vec_width-1:0]    u_z,
  input  logic signed [vec_width-1:0]    v_x,
  input  logic signed [vec_width-1:0]    v_y,
  input  logic signed [vec_width-1:0]    v_z,
  input  logic signed [vec_width-1:0]    n_x,
  input  logic signed [vec_width-1:0]    n_y,
  input  logic signed [vec_width-1:0]    n_z,
  input  logic                           res_ready,
  output logic                           vtx_accept,
  output logic                           res_valid,
  output logic [tag_width-1:0]           res_tag,
  output logic                           res_culled,
  output logic signed [screen_width-1:0] res_x,
  output logic signed [screen_width-1:0] res_y,
  output logic signed [dot_width-1:0]    res_depth
);

  logic [num_lanes-1:0] lane_start, lane_busy, lane_done, lane_take, lane_culled;
  logic signed [pos_width-1:0]             lane_x, lane_y, lane_z;  // shared vertex
  logic [tag_width-1:0]                    lane_tag_in;
  logic [num_lanes-1:0][tag_width-1:0]     lane_tag;
  logic [num_lanes-1:0][screen_width-1:0]  lane_scr_x, lane_scr_y;
  logic [num_lanes-1:0][dot_width-1:0]     lane_depth;

  vertex_dispatch #(.num_lanes(num_lanes)) u_dispatch (
    .clk_in(clk_in), .rst_in(rst_in), .vtx_valid(vtx_valid),
    .vtx_x(vtx_x), .vtx_y(vtx_y), .vtx_z(vtx_z), .lane_busy(lane_busy),
    .vtx_accept(vtx_accept), .lane_start(lane_start),
    .lane_x(lane_x), .lane_y(lane_y), .lane_z(lane_z), .lane_tag(lane_tag_in)
  );

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    vertex_projector #(.half_w(half_w), .half_h(half_h), .focal_shift(focal_shift)) u_lane (
      .clk_in(clk_in), .rst_in(rst_in), .start(lane_start[i]),
      .vtx_x(lane_x), .vtx_y(lane_y), .vtx_z(lane_z), .tag_in(lane_tag_in),
      .cam_x(cam_x), .cam_y(cam_y), .cam_z(cam_z),
      .u_x(u_x), .u_y(u_y), .u_z(u_z), .v_x(v_x), .v_y(v_y), .v_z(v_z),
      .n_x(n_x), .n_y(n_y), .n_z(n_z), .take(lane_take[i]),
      .busy(lane_busy[i]), .done(lane_done[i]), .tag(lane_tag[i]),
      .culled(lane_culled[i]), .scr_x(lane_scr_x[i]), .scr_y(lane_scr_y[i]),
      .depth(lane_depth[i])
    );
  end

  result_collect #(.num_lanes(num_lanes)) u_collect (
    .clk_in(clk_in), .rst_in(rst_in), .res_ready(res_ready), .lane_done(lane_done),
    .lane_tag(lane_tag), .lane_culled(lane_culled), .lane_x(lane_scr_x),
    .lane_y(lane_scr_y), .lane_depth(lane_depth), .lane_take(lane_take),
    .res_valid(res_valid), .res_tag(res_tag), .res_culled(res_culled),
    .res_x(res_x), .res_y(res_y), .res_depth(res_depth)
  );

endmodule

//--- verilog/result_collect.sv
`timescale 1ns/1ps

module result_collect import geom_pkg::*, proj_pkg::*; #(
  parameter int num_lanes = 3
) (
  input  logic                                   clk_in,
  input  logic                                   rst_in,
  input  logic                                   res_ready,
  input  logic [num_lanes-1:0]                   lane_done,
  input  logic [num_lanes-1:0][tag_width-1:0]    lane_tag,
  input  logic [num_lanes-1:0]                   lane_culled,
  input  logic [num_lanes-1:0][screen_width-1:0] lane_x,
  input  logic [num_lanes-1:0][screen_width-1:0] lane_y,
  input  logic [num_lanes-1:0][dot_width-1:0]    lane_depth,
  output logic [num_lanes-1:0]                   lane_take,
  output logic                                   res_valid,
  output logic [tag_width-1:0]                   res_tag,
  output logic                                   res_culled,
  output logic signed [screen_width-1:0]         res_x,
  output logic signed [screen_width-1:0]         res_y,
  output logic signed [dot_width-1:0]            res_depth
);

  localparam int sel_width = (num_lanes > 1) ? $clog2(num_lanes) : 1;

  logic                 can_load;
  logic [sel_width-1:0] sel;

  // register empty or draining this cycle
  assign can_load = !res_valid || res_ready;

  // fixed priority, lane 0 wins
  always_comb begin
    sel = '0;
    for (int i = num_lanes - 1; i >= 0; i--) begin
      if (lane_done[i]) sel = sel_width'(i);
    end
  end

  assign lane_take = (can_load && |lane_done) ? (num_lanes'(1) << sel) : '0;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      res_valid <= 1'b0;
    end else if (can_load) begin
      res_valid <= |lane_done;
    end
  end

  always_ff @(posedge clk_in) begin
    if (|lane_take) begin
      res_tag    <= lane_tag[sel];
      res_culled <= lane_culled[sel];
      res_x      <= lane_x[sel];
      res_y      <= lane_y[sel];
      res_depth  <= lane_depth[sel];
    end
  end

  // one lane per cycle, and only a lane that is holding a result
  take_one_done_lane: assert property (@(posedge clk_in) disable iff (rst_in)
    $onehot0(lane_take) && ((lane_take & ~lane_done) == '0))
    else $error("bad lane_take pattern");

endmodule

//--- verilog/vertex_dispatch.sv
`timescale 1ns/1ps

module vertex_dispatch import geom_pkg::*, proj_pkg::*; #(
  parameter int num_lanes = 3
) (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        vtx_valid,
  input  logic signed [pos_width-1:0] vtx_x,
  input  logic signed [pos_width-1:0] vtx_y,
  input  logic signed [pos_width-1:0] vtx_z,
  input  logic [num_lanes-1:0]        lane_busy,
  output logic                        vtx_accept,
  output logic [num_lanes-1:0]        lane_start,
  output logic signed [pos_width-1:0] lane_x,
  output logic signed [pos_width-1:0] lane_y,
  output logic signed [pos_width-1:0] lane_z,
  output logic [tag_width-1:0]        lane_tag
);

  logic [num_lanes-1:0] free_lanes;
  logic [num_lanes-1:0] pick;
  logic [tag_width-1:0] tag_cnt;

  // a lane started last cycle only shows busy one cycle later
  assign free_lanes = ~lane_busy & ~lane_start;
  assign pick       = free_lanes & (~free_lanes + 1'b1);  // lowest free lane
  assign vtx_accept = |free_lanes;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      lane_start <= '0;
      tag_cnt    <= '0;
    end else begin
      lane_start <= vtx_valid ? pick : '0;
      if (vtx_valid && vtx_accept) tag_cnt <= tag_cnt + 1'b1;  // wraps
    end
  end

  always_ff @(posedge clk_in) begin
    if (vtx_valid && vtx_accept) begin
      lane_x   <= vtx_x;
      lane_y   <= vtx_y;
      lane_z   <= vtx_z;
      lane_tag <= tag_cnt;
    end
  end

  strobe_needs_accept: assert property (@(posedge clk_in) disable iff (rst_in)
    vtx_valid |-> vtx_accept)
    else $error("vertex strobe while no lane is free");

  // a started lane must have been idle
  start_to_idle_lane: assert property (@(posedge clk_in) disable iff (rst_in)
    (lane_start & lane_busy) == '0)
    else $error("start given to a busy lane");

endmodule

//--- verilog/vertex_projector.sv
`timescale 1ns/1ps

module vertex_projector import geom_pkg::*, proj_pkg::*; #(
  parameter int half_w      = 160,
  parameter int half_h      = 120,
  parameter int focal_shift = 8
) (
  input  logic                           clk_in,
  input  logic                           rst_in,
  input  logic                           start,
  input  logic signed [pos_width-1:0]    vtx_x,
  input  logic signed [pos_width-1:0]    vtx_y,
  input  logic signed [pos_width-1:0]    vtx_z,
  input  logic [tag_width-1:0]           tag_in,
  input  logic signed [cam_width-1:0]    cam_x,
  input  logic signed [cam_width-1:0]    cam_y,
  input  logic signed [cam_width-1:0]    cam_z,
  input  logic signed [vec_width-1:0]    u_x,
  input  logic signed [vec_width-1:0]    u_y,
  input  logic signed [vec_width-1:0]    u_z,
  input  logic signed [vec_width-1:0]    v_x,
  input  logic signed [vec_width-1:0]    v_y,
  input  logic signed [vec_width-1:0]    v_z,
  input  logic signed [vec_width-1:0]    n_x,
  input  logic signed [vec_width-1:0]    n_y,
  input  logic signed [vec_width-1:0]    n_z,
  input  logic                           take,
  output logic                           busy,
  output logic                           done,
  output logic [tag_width-1:0]           tag,
  output logic                           culled,
  output logic signed [screen_width-1:0] scr_x,
  output logic signed [screen_width-1:0] scr_y,
  output logic signed [dot_width-1:0]    depth
);

  localparam logic signed [quot_width-1:0] half_w_q = quot_width'(half_w);
  localparam logic signed [quot_width-1:0] half_h_q = quot_width'(half_h);

  lane_state_t state;
  logic dot_wait;
  logic check, div_go, in_view;
  logic x_got, y_got;
  logic x_done, y_done;
  logic signed [rel_width-1:0]  rel_x, rel_y, rel_z;
  logic signed [dot_width-1:0]  u_dot, v_dot, n_dot;
  logic signed [quot_width-1:0] dividend_x, dividend_y, divisor_n;
  logic signed [quot_width-1:0] x_quot, y_quot, quot_x, quot_y;

  // shared vertex register is sampled in the start cycle
  assign rel_x = vtx_x - cam_x;
  assign rel_y = vtx_y - cam_y;
  assign rel_z = vtx_z - cam_z;

  dot3_fixed dot_u (.clk_in(clk_in), .rst_in(rst_in), .a_x(rel_x), .a_y(rel_y), .a_z(rel_z),
                    .b_x(u_x), .b_y(u_y), .b_z(u_z), .dot(u_dot));
  dot3_fixed dot_v (.clk_in(clk_in), .rst_in(rst_in), .a_x(rel_x), .a_y(rel_y), .a_z(rel_z),
                    .b_x(v_x), .b_y(v_y), .b_z(v_z), .dot(v_dot));
  dot3_fixed dot_n (.clk_in(clk_in), .rst_in(rst_in), .a_x(rel_x), .a_y(rel_y), .a_z(rel_z),
                    .b_x(n_x), .b_y(n_y), .b_z(n_z), .dot(n_dot));

  assign check  = (state == DOT) && dot_wait;  // dots for this vertex are valid now
  assign div_go = check && (n_dot > 0);

  assign dividend_x = quot_width'(u_dot) <<< focal_shift;  // focal scale
  assign dividend_y = quot_width'(v_dot) <<< focal_shift;
  assign divisor_n  = quot_width'(n_dot);

  fixed_div div_x (.clk_in(clk_in), .rst_in(rst_in), .start(div_go), .dividend(dividend_x),
                   .divisor(divisor_n), .busy(), .done(x_done), .zerodiv(),
                   .quotient(x_quot));
  fixed_div div_y (.clk_in(clk_in), .rst_in(rst_in), .start(div_go), .dividend(dividend_y),
                   .divisor(divisor_n), .busy(), .done(y_done), .zerodiv(),
                   .quotient(y_quot));

  // open ranges around the viewport centre
  assign in_view = (quot_x > -half_w_q) && (quot_x < half_w_q) &&
                   (quot_y > -half_h_q) && (quot_y < half_h_q);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= IDLE;
      dot_wait <= 1'b0;
      culled   <= 1'b0;
      x_got    <= 1'b0;
      y_got    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state    <= DOT;
            dot_wait <= 1'b0;
            culled   <= 1'b0;
          end
        end
        DOT: begin
          dot_wait <= 1'b1;
          if (check) begin
            x_got <= 1'b0;
            y_got <= 1'b0;
            if (n_dot <= 0) begin  // behind or on the camera plane
              culled <= 1'b1;
              state  <= HOLD;
            end else begin
              state <= DIVIDE;
            end
          end
        end
        DIVIDE: begin
          if (x_done) x_got <= 1'b1;
          if (y_done) y_got <= 1'b1;
          if (x_got && y_got) begin
            culled <= !in_view;
            state  <= HOLD;
          end
        end
        HOLD:    if (take) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == IDLE && start) tag <= tag_in;
    if (check) depth <= n_dot;
    if (x_done) quot_x <= x_quot;
    if (y_done) quot_y <= y_quot;
  end

  assign busy  = (state != IDLE);
  assign done  = (state == HOLD);
  assign scr_x = culled ? '0 : screen_width'(quot_x + half_w_q);
  assign scr_y = culled ? '0 : screen_width'(half_h_q - quot_y);  // screen y grows downward

  // the collector only takes lanes that are holding a result
  take_only_in_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    take |-> state == HOLD)
    else $error("lane take outside HOLD");

endmodule
